/* Makefile */
VERILATOR  ?= verilator
TOP        ?= rider_status_tb
RTL_TOP    ?= rider_status_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+100
FAIL_MSG   := Done: errors found
PASS_MSG   := Done: no errors

.PHONY: run build lint clean

run: build
	-$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/rider_status_pkg.sv */
package rider_status_pkg;

  // Firmware version
  localparam logic [7:0] major_rev = 8'd3;
  localparam logic [7:0] minor_rev = 8'd1;
  localparam logic [7:0] patch_rev = 8'd0;

  localparam int num_status_regs = 29;
  localparam int status_addr_w   = 5;

  localparam int num_chan    = 5;
  localparam int burst_w     = 23;
  localparam int trig_num_w  = 24;
  localparam int timestamp_w = 44;

  // Register map indices
  localparam int reg_version        = 0;
  localparam int reg_error          = 1;
  localparam int reg_clock_temp     = 2;
  localparam int reg_clk_synth      = 3;
  localparam int reg_daq_link       = 4;
  localparam int reg_ttc_tts        = 5;
  localparam int reg_fsm_state0     = 6;
  localparam int reg_fsm_state1     = 7;
  localparam int reg_acq            = 8;
  localparam int reg_trig_info      = 9;
  localparam int reg_trig_delay     = 10;
  localparam int reg_trig_num       = 11;
  localparam int reg_trig_ts_lsb    = 12;
  localparam int reg_trig_ts_msb    = 13;
  localparam int reg_fp_trig_num    = 14;
  localparam int reg_cs_thres       = 15;
  localparam int reg_cs_count       = 16;
  localparam int reg_unknown_thres  = 17;
  localparam int reg_unknown_count  = 18;
  localparam int reg_ovf_thres      = 19;
  localparam int reg_ovf_count      = 20;
  // Channels 0 to 4 follow in consecutive words
  localparam int reg_burst_chan0    = 21;
  localparam int reg_xadc_temp_int  = 26;
  localparam int reg_xadc_aux_bram  = 27;
  localparam int reg_xadc_alarm     = 28;

  typedef logic [31:0] status_word_t;
  typedef status_word_t [num_status_regs-1:0] status_regs_t;

  typedef struct packed {
    logic [31:0] count;
    logic [31:0] threshold;
    logic        error;
  } soft_err_t;

  typedef struct packed {
    logic [trig_num_w-1:0]  trig_num;
    logic [timestamp_w-1:0] trig_timestamp;
  } trig_info_t;

  typedef struct packed {
    // FPGA status
    logic is_golden;
    logic prog_chan_done;
    logic async_mode;
    // Hard errors and warnings
    logic error_data_corrupt;
    logic error_trig_num_from_tt;
    logic error_trig_type_from_tt;
    logic error_trig_num_from_cm;
    logic error_trig_type_from_cm;
    logic error_pll_unlock;
    logic error_trig_rate;
    logic error_unknown_ttc;
    logic ddr3_almost_full;
    logic [num_chan-1:0] chan_error_sn;
    logic [num_chan-1:0] chan_error_rc;
    // Clocking
    logic daq_clk_sel;
    logic daq_clk_en;
    logic adcclk_clkin0_stat;
    logic adcclk_clkin1_stat;
    logic adcclk_stat_ld;
    logic adcclk_stat;
    // DAQ link and TTC/TTS
    logic daq_almost_full;
    logic daq_ready;
    logic [3:0] tts_state;
    logic [5:0] ttc_chan_b_info;
    logic ttc_ready;
    // FSM states
    logic [33:0] cm_state;
    logic [3:0]  ttr_state;
    logic [3:0]  ptr_state;
    logic [3:0]  cac_state;
    logic [3:0]  caca_state;
    logic [6:0]  tp_state;
    // Acquisition
    logic [num_chan-1:0] acq_readout_pause;
    logic [num_chan-1:0] fill_type;
    logic [num_chan-1:0] chan_en;
    logic endianness_sel;
    logic [num_chan-1:0] acq_dones;
    // Trigger
    logic trig_fifo_full;
    logic acq_fifo_full;
    logic [31:0] trig_delay;
    logic [2:0]  trig_settings;
    logic [trig_num_w-1:0] pulse_trig_num;
    // Slow control
    logic [11:0] i2c_temp;
    logic [15:0] xadc_temp;
    logic [15:0] xadc_vccint;
    logic [15:0] xadc_vccaux;
    logic [15:0] xadc_vccbram;
    logic xadc_over_temp;
    logic xadc_alarm_temp;
    logic xadc_alarm_vccint;
    logic xadc_alarm_vccaux;
    logic xadc_alarm_vccbram;
    // DDR3 stored bursts per channel
    logic [num_chan-1:0][burst_w-1:0] stored_bursts;
  } board_status_t;

endpackage

/* hw/rider_status_top.sv */
`timescale 1ns/10ps

module rider_status_top import rider_status_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  board_status_t            board,
  // Soft error events and trigger
  input  logic                     cs_mismatch,
  input  logic                     unknown_cmd,
  input  logic                     ddr3_overflow,
  input  logic                     trig,
  // Soft error thresholds
  input  logic [31:0]              thres_data_corrupt,
  input  logic [31:0]              thres_unknown_ttc,
  input  logic [31:0]              thres_ddr3_overflow,
  input  logic                     err_clr,
  // Register read port
  input  logic                     rd_en,
  input  logic [status_addr_w-1:0] rd_addr,
  output status_word_t             rd_data,
  output logic                     rd_ack,
  output logic                     rd_err,
  // Bit 0 data corrupt, bit 1 unknown TTC, bit 2 DDR3 overflow
  output logic [2:0]               soft_err_flags
);

  soft_err_t    cs_status;
  soft_err_t    unknown_status;
  soft_err_t    ovf_status;
  trig_info_t   trig_info;
  status_regs_t regs;

  soft_error_counter cs_cnt_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .event_pulse (cs_mismatch),
    .clear       (err_clr),
    .threshold   (thres_data_corrupt),
    .status      (cs_status)
  );

  soft_error_counter unknown_cnt_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .event_pulse (unknown_cmd),
    .clear       (err_clr),
    .threshold   (thres_unknown_ttc),
    .status      (unknown_status)
  );

  soft_error_counter ovf_cnt_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .event_pulse (ddr3_overflow),
    .clear       (err_clr),
    .threshold   (thres_ddr3_overflow),
    .status      (ovf_status)
  );

  trigger_tracker trig_i (
    .clk   (clk),
    .rst_n (rst_n),
    .trig  (trig),
    .info  (trig_info)
  );

  status_reg_block regs_i (
    .board       (board),
    .cs_err      (cs_status),
    .unknown_err (unknown_status),
    .ovf_err     (ovf_status),
    .trig_info   (trig_info),
    .regs        (regs)
  );

  status_read_port rd_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .regs    (regs),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_ack  (rd_ack),
    .rd_err  (rd_err)
  );

  assign soft_err_flags = {ovf_status.error, unknown_status.error, cs_status.error};

endmodule

/* hw/soft_error_counter.sv */
`timescale 1ns/10ps

module soft_error_counter import rider_status_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        event_pulse,
  input  logic        clear,
  input  logic [31:0] threshold,
  output soft_err_t   status
);

  logic [31:0] count;
  logic [31:0] count_next;
  logic        error;
  logic        error_next;

  // Saturating increment where clear has priority over a new event
  always_comb begin
    count_next = count;
    if (clear) begin
      count_next = '0;
    end else if (event_pulse && (count != '1)) begin
      count_next = count + 32'd1;
    end
  end

  // Flag compares the updated count so it rises together with it
  always_comb begin
    if (clear) begin
      error_next = 1'b0;
    end else begin
      error_next = error | ((threshold != '0) && (count_next >= threshold));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
      error <= 1'b0;
    end else begin
      count <= count_next;
      error <= error_next;
    end
  end

  // Threshold rides along so the map shows it beside the count
  assign status.count     = count;
  assign status.threshold = threshold;
  assign status.error     = error;

endmodule

/* hw/status_read_port.sv */
`timescale 1ns/10ps

module status_read_port import rider_status_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  status_regs_t             regs,
  input  logic                     rd_en,
  input  logic [status_addr_w-1:0] rd_addr,
  output status_word_t             rd_data,
  output logic                     rd_ack,
  output logic                     rd_err
);

  logic addr_ok;

  // Words past the end of the map are rejected here only
  assign addr_ok = rd_addr < status_addr_w'(num_status_regs);

  // Acknowledge and error are one-cycle pulses per strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ack <= 1'b0;
      rd_err <= 1'b0;
    end else begin
      rd_ack <= rd_en;
      rd_err <= rd_en && !addr_ok;
    end
  end

  // Data holds the last read word until the next strobe
  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (addr_ok) begin
        rd_data <= regs[rd_addr];
      end else begin
        rd_data <= '0;
      end
    end
  end

endmodule

/* hw/status_reg_block.sv */
`timescale 1ns/10ps

module status_reg_block import rider_status_pkg::*; (
  input  board_status_t board,
  input  soft_err_t     cs_err,
  input  soft_err_t     unknown_err,
  input  soft_err_t     ovf_err,
  input  trig_info_t    trig_info,
  output status_regs_t  regs
);

  always_comb begin
    // FPGA status and firmware version
    regs[reg_version] = {board.is_golden, board.prog_chan_done, board.async_mode, 5'd0,
                         major_rev, minor_rev, patch_rev};

    // Hard errors merged with the sticky soft error flags
    regs[reg_error] = {13'd0,
                       board.ddr3_almost_full | ovf_err.error,
                       board.chan_error_rc,
                       board.chan_error_sn,
                       board.error_trig_type_from_cm,
                       board.error_trig_type_from_tt,
                       board.error_trig_num_from_cm,
                       board.error_trig_num_from_tt,
                       board.error_data_corrupt | cs_err.error,
                       board.error_trig_rate,
                       board.error_unknown_ttc | unknown_err.error,
                       board.error_pll_unlock};

    regs[reg_clock_temp] = {board.i2c_temp, 18'd0, board.daq_clk_sel, board.daq_clk_en};

    regs[reg_clk_synth] = {28'd0, board.adcclk_clkin1_stat, board.adcclk_clkin0_stat,
                           board.adcclk_stat_ld, board.adcclk_stat};

    regs[reg_daq_link] = {30'd0, board.daq_almost_full, board.daq_ready};

    regs[reg_ttc_tts] = {21'd0, board.tts_state, board.ttc_chan_b_info, board.ttc_ready};

    // FSM states with cm_state spilling into the second word
    regs[reg_fsm_state0] = board.cm_state[31:0];
    regs[reg_fsm_state1] = {board.cm_state[33:32], 7'd0, board.tp_state,
                            board.caca_state, board.cac_state,
                            board.ptr_state, board.ttr_state};

    regs[reg_acq] = {11'd0, board.acq_dones, board.endianness_sel,
                     board.acq_readout_pause, board.fill_type, board.chan_en};

    // TTC trigger words
    regs[reg_trig_info]   = {27'd0, board.trig_settings, board.acq_fifo_full,
                             board.trig_fifo_full};
    regs[reg_trig_delay]  = board.trig_delay;
    regs[reg_trig_num]    = {8'd0, trig_info.trig_num};
    regs[reg_trig_ts_lsb] = trig_info.trig_timestamp[31:0];
    regs[reg_trig_ts_msb] = {20'd0, trig_info.trig_timestamp[43:32]};
    regs[reg_fp_trig_num] = {8'd0, board.pulse_trig_num};

    // Soft error thresholds and counts
    regs[reg_cs_thres]      = cs_err.threshold;
    regs[reg_cs_count]      = cs_err.count;
    regs[reg_unknown_thres] = unknown_err.threshold;
    regs[reg_unknown_count] = unknown_err.count;
    regs[reg_ovf_thres]     = ovf_err.threshold;
    regs[reg_ovf_count]     = ovf_err.count;

    // One burst count word per channel
    for (int i = 0; i < num_chan; i++) begin
      regs[reg_burst_chan0 + i] = {9'd0, board.stored_bursts[i]};
    end

    // XADC readings and alarms
    regs[reg_xadc_temp_int] = {board.xadc_vccint, board.xadc_temp};
    regs[reg_xadc_aux_bram] = {board.xadc_vccbram, board.xadc_vccaux};
    regs[reg_xadc_alarm]    = {27'd0, board.xadc_alarm_vccbram, board.xadc_alarm_vccaux,
                               board.xadc_alarm_vccint, board.xadc_alarm_temp,
                               board.xadc_over_temp};
  end

endmodule

/* hw/trigger_tracker.sv */
`timescale 1ns/10ps

module trigger_tracker import rider_status_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       trig,
  output trig_info_t info
);

  logic [timestamp_w-1:0] ts_count;
  logic [timestamp_w-1:0] ts_latch;
  logic [trig_num_w-1:0]  trig_count;

  // Free-running timestamp with one tick per clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ts_count <= '0;
    end else begin
      ts_count <= ts_count + 1'b1;
    end
  end

  // Trigger number wraps at 24 bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_count <= '0;
    end else if (trig) begin
      trig_count <= trig_count + 1'b1;
    end
  end

  // Timestamp of the most recent trigger
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ts_latch <= '0;
    end else if (trig) begin
      ts_latch <= ts_count;
    end
  end

  assign info.trig_num       = trig_count;
  assign info.trig_timestamp = ts_latch;

endmodule

/* project.f */
hw/rider_status_pkg.sv
hw/soft_error_counter.sv
hw/trigger_tracker.sv
hw/status_reg_block.sv
hw/status_read_port.sv
hw/rider_status_top.sv
sim/rider_status_assert.sv
sim/rider_status_tb.sv

/* sim/rider_status_assert.sv */
`timescale 1ns/10ps

module rider_status_assert import rider_status_pkg::*; (
  input logic                     clk,
  input logic                     rst_n,
  input board_status_t            board,
  input logic                     cs_mismatch,
  input logic                     unknown_cmd,
  input logic                     ddr3_overflow,
  input logic                     trig,
  input logic [31:0]              thres_data_corrupt,
  input logic [31:0]              thres_unknown_ttc,
  input logic [31:0]              thres_ddr3_overflow,
  input logic                     err_clr,
  input logic                     rd_en,
  input logic [status_addr_w-1:0] rd_addr,
  input status_word_t             rd_data,
  input logic                     rd_ack,
  input logic                     rd_err,
  input logic [2:0]               soft_err_flags
);

  logic [2:0]             ev;
  logic [2:0][31:0]       thr;
  logic [2:0][31:0]       cnt_exp;
  logic [2:0]             flg_exp;
  logic [trig_num_w-1:0]  trig_exp;
  logic [trig_num_w-1:0]  trig_at_read;
  logic [timestamp_w-1:0] ts_exp;
  logic [timestamp_w-1:0] ts_latch_exp;
  status_word_t           ts_last_read;
  logic                   ts_read_seen;
  logic [status_addr_w-1:0] last_addr;
  logic                   last_oor;
  status_word_t           exp_word;
  logic                   exp_valid;
  int                     fail_count = 0;

  // Index 0 data corrupt, 1 unknown TTC, 2 DDR3 overflow
  assign ev       = {ddr3_overflow, unknown_cmd, cs_mismatch};
  assign thr      = {thres_ddr3_overflow, thres_unknown_ttc, thres_data_corrupt};
  assign last_oor = int'(last_addr) >= num_status_regs;

  // Version in the low three bytes and FPGA status in the top bits
  function automatic status_word_t version_word(input board_status_t b);
    status_word_t w;
    w        = '0;
    w[7:0]   = patch_rev;
    w[15:8]  = minor_rev;
    w[23:16] = major_rev;
    w[29]    = b.async_mode;
    w[30]    = b.prog_chan_done;
    w[31]    = b.is_golden;
    return w;
  endfunction

  // Hard error bits with the soft flags merged in
  function automatic status_word_t error_word(input board_status_t b, input logic [2:0] f);
    status_word_t w;
    w        = '0;
    w[0]     = b.error_pll_unlock;
    w[1]     = b.error_unknown_ttc | f[1];
    w[2]     = b.error_trig_rate;
    w[3]     = b.error_data_corrupt | f[0];
    w[4]     = b.error_trig_num_from_tt;
    w[5]     = b.error_trig_num_from_cm;
    w[6]     = b.error_trig_type_from_tt;
    w[7]     = b.error_trig_type_from_cm;
    w[12:8]  = b.chan_error_sn;
    w[17:13] = b.chan_error_rc;
    w[18]    = b.ddr3_almost_full | f[2];
    return w;
  endfunction

  // Shadow counters, flags and trigger state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_exp      <= '0;
      flg_exp      <= '0;
      trig_exp     <= '0;
      ts_exp       <= '0;
      ts_latch_exp <= '0;
    end else begin
      ts_exp <= ts_exp + 1'b1;
      if (trig) begin
        trig_exp     <= trig_exp + 1'b1;
        ts_latch_exp <= ts_exp;
      end
      for (int i = 0; i < 3; i++) begin
        if (err_clr) begin
          cnt_exp[i] <= '0;
          flg_exp[i] <= 1'b0;
        end else if (ev[i] && (cnt_exp[i] != '1)) begin
          cnt_exp[i] <= cnt_exp[i] + 32'd1;
          if ((thr[i] != '0) && (cnt_exp[i] + 32'd1 >= thr[i])) begin
            flg_exp[i] <= 1'b1;
          end
        end
      end
    end
  end

  // Expected word captured with each strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_addr    <= '0;
      exp_word     <= '0;
      exp_valid    <= 1'b0;
      ts_last_read <= '0;
      trig_at_read <= '0;
      ts_read_seen <= 1'b0;
    end else begin
      if (rd_en) begin
        last_addr <= rd_addr;
        exp_valid <= 1'b1;
        case (int'(rd_addr))
          reg_version:       exp_word <= version_word(board);
          reg_error:         exp_word <= error_word(board, flg_exp);
          reg_trig_num:      exp_word <= {8'd0, trig_exp};
          reg_trig_ts_lsb:   exp_word <= ts_latch_exp[31:0];
          reg_trig_ts_msb:   exp_word <= {20'd0, ts_latch_exp[43:32]};
          reg_cs_count:      exp_word <= cnt_exp[0];
          reg_unknown_count: exp_word <= cnt_exp[1];
          reg_ovf_count:     exp_word <= cnt_exp[2];
          default: begin
            exp_word  <= '0;
            exp_valid <= int'(rd_addr) >= num_status_regs;
          end
        endcase
      end
      if (rd_ack && (int'(last_addr) == reg_trig_ts_lsb)) begin
        ts_last_read <= exp_word;
        trig_at_read <= trig_exp;
        ts_read_seen <= 1'b1;
      end
    end
  end

  a_ack_follows_rd: assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> rd_ack)
    else begin
      $error("Fail read_timing: expected rd_ack 1, actual %0b", $sampled(rd_ack));
      fail_count++;
    end

  a_no_stray_ack: assert property (@(posedge clk) disable iff (!rst_n) !rd_en |=> !rd_ack)
    else begin
      $error("Fail read_timing: expected rd_ack 0, actual %0b", $sampled(rd_ack));
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clk)
      !rst_n |-> (!rd_ack && !rd_err && (soft_err_flags == 3'b000)))
    else begin
      $error("Reset did not clear rd_ack, rd_err and the soft error flags");
      fail_count++;
    end

  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
      rd_ack |-> (rd_err == last_oor))
    else begin
      $error("Fail addr_range: expected rd_err %0b, actual %0b", $sampled(last_oor),
             $sampled(rd_err));
      fail_count++;
    end

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_ack && exp_valid) |-> (rd_data == exp_word))
    else begin
      $error("Fail read_data addr %0d: expected %h, actual %h", $sampled(last_addr),
             $sampled(exp_word), $sampled(rd_data));
      fail_count++;
    end

  a_soft_flags: assert property (@(posedge clk) disable iff (!rst_n)
      soft_err_flags == flg_exp)
    else begin
      $error("Fail soft_err_flags: expected %b, actual %b", $sampled(flg_exp),
             $sampled(soft_err_flags));
      fail_count++;
    end

  // Timestamp must move forward once a new trigger has arrived
  a_ts_increase: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_ack && (int'(last_addr) == reg_trig_ts_lsb) && ts_read_seen &&
       (trig_exp != trig_at_read)) |-> (rd_data > ts_last_read))
    else begin
      $error("Fail trig_timestamp: expected above %h, actual %h", $sampled(ts_last_read),
             $sampled(rd_data));
      fail_count++;
    end

endmodule

/* sim/rider_status_tb.sv */
`timescale 1ns/10ps

module rider_status_tb import rider_status_pkg::*; ();

  localparam int board_words = ($bits(board_status_t) + 31) / 32;

  logic                     clk;
  logic                     rst_n;
  board_status_t            board;
  logic                     cs_mismatch;
  logic                     unknown_cmd;
  logic                     ddr3_overflow;
  logic                     trig;
  logic [31:0]              thres_data_corrupt;
  logic [31:0]              thres_unknown_ttc;
  logic [31:0]              thres_ddr3_overflow;
  logic                     err_clr;
  logic                     rd_en;
  logic [status_addr_w-1:0] rd_addr;
  status_word_t             rd_data;
  logic                     rd_ack;
  logic                     rd_err;
  logic [2:0]               soft_err_flags;
  integer                   seed;

  rider_status_top dut_i (.*);

  bind rider_status_top rider_status_assert chk_i (.*);

  always #10 clk = ~clk;

  // Stop at the first failed assertion
  always @(posedge clk) begin
    if (dut_i.chk_i.fail_count != 0) begin
      $display("Done: errors found");
      $fatal(1, "A status assertion failed");
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Done: errors found");
    $fatal(1, "Wait timed out");
  endtask

  task automatic randomize_board();
    logic [board_words*32-1:0] raw;
    for (int i = 0; i < board_words; i++) begin
      raw[i*32 +: 32] = $random(seed);
    end
    board = raw[$bits(board_status_t)-1:0];
  endtask

  // One pulse every other cycle on the selected event inputs
  task automatic send_events(input int n, input logic [2:0] sel);
    for (int i = 0; i < n; i++) begin
      {ddr3_overflow, unknown_cmd, cs_mismatch} = sel;
      next_cycle();
      {ddr3_overflow, unknown_cmd, cs_mismatch} = 3'b000;
      next_cycle();
    end
  endtask

  task automatic read_word(input int addr);
    int t;
    rd_en   = 1'b1;
    rd_addr = status_addr_w'(addr);
    next_cycle();
    rd_en = 1'b0;
    t = 0;
    while (!rd_ack) begin
      if (t == 10) report_timeout($sformatf("no read acknowledge for address %0d", addr));
      t++;
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic wait_flag(input int idx);
    int t;
    t = 0;
    while (!soft_err_flags[idx]) begin
      if (t == 20) report_timeout($sformatf("soft error flag %0d never rose", idx));
      t++;
      next_cycle();
    end
  endtask

  initial begin
    clk                 = 1'b0;
    rst_n               = 1'b0;
    seed                = 32'hbef4;
    {ddr3_overflow, unknown_cmd, cs_mismatch} = 3'b000;
    trig                = 1'b0;
    err_clr             = 1'b0;
    rd_en               = 1'b0;
    rd_addr             = '0;
    // Low thresholds on data corrupt and DDR3 overflow and none on unknown TTC
    thres_data_corrupt  = 32'd4;
    thres_unknown_ttc   = 32'd0;
    thres_ddr3_overflow = 32'd5;
    randomize_board();
    repeat (4) next_cycle();
    rst_n = 1'b1;
    next_cycle();

    for (int a = 0; a < num_status_regs; a++) read_word(a);

    send_events(6, 3'b001);
    wait_flag(0);
    send_events(3, 3'b010);
    send_events(5, 3'b100);
    wait_flag(2);
    read_word(reg_cs_count);
    read_word(reg_unknown_count);
    read_word(reg_ovf_count);
    read_word(reg_error);

    // Clear wins over an event in the same cycle
    err_clr     = 1'b1;
    cs_mismatch = 1'b1;
    next_cycle();
    err_clr     = 1'b0;
    cs_mismatch = 1'b0;
    next_cycle();
    read_word(reg_cs_count);
    read_word(reg_error);

    randomize_board();
    read_word(reg_version);
    read_word(reg_error);
    send_events(2, 3'b111);

    for (int i = 0; i < 5; i++) begin
      trig = 1'b1;
      next_cycle();
      trig = 1'b0;
      repeat (i + 1) next_cycle();
      read_word(reg_trig_ts_lsb);
    end
    read_word(reg_trig_num);
    read_word(reg_trig_ts_msb);

    // Full sweep plus two words past the end of the map
    for (int a = 0; a < num_status_regs + 2; a++) read_word(a);
    repeat (2) next_cycle();

    if (dut_i.chk_i.fail_count != 0) begin
      $display("Done: errors found");
      $fatal(1, "Status assertions failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule
